/* design/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    // data, address and instruction words
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // only the opcodes this core executes, anything else runs as a nop
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    // funct3 encoding, alt bit picks sub and sra
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    // low two funct3 bits of loads and stores
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    typedef enum logic [2:0] {
        wb_alu_out,
        wb_u_imm,
        wb_lw,
        wb_lh,
        wb_lhu,
        wb_lb,
        wb_lbu
    } wb_sel_e;

    // operand source picked in front of decode
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_ex,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    // all zero is a nop
    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_alt;
        logic      b_imm;
        logic      mem_read;
        logic      mem_write;
        mem_size_e size;
        wb_sel_e   wb_sel;
        logic      reg_write;
    } ctrl_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter rv32i_pkg::word_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             advance,
    input  rv32i_pkg::word_t instr_rdata,
    output rv32i_pkg::word_t instr_addr,
    output rv32i_pkg::word_t id_instr
);

    // next fetch address, one word ahead of the request
    rv32i_pkg::word_t pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= RESET_PC + 32'd4;
            instr_addr <= RESET_PC;
        end else if (advance) begin
            pc         <= pc + 32'd4;
            instr_addr <= pc;
        end
    end

    // IF/ID, starts out holding a nop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_instr <= rv32i_pkg::NOP_INSTR;
        end else if (advance) begin
            id_instr <= instr_rdata;
        end
    end

    // a misaligned reset pc would never be fixed up
    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) instr_addr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                bubble,
    input  rv32i_pkg::word_t    id_instr,
    input  rv32i_pkg::word_t    rs1_val,
    input  rv32i_pkg::word_t    rs2_val,
    output rv32i_pkg::reg_idx_t rs1,
    output rv32i_pkg::reg_idx_t rs2,
    output rv32i_pkg::ctrl_t    ex_ctrl,
    output rv32i_pkg::reg_idx_t ex_rd,
    output rv32i_pkg::word_t    ex_a,
    output rv32i_pkg::word_t    ex_b,
    output rv32i_pkg::word_t    ex_imm
);

    logic [2:0]          funct3;
    rv32i_pkg::reg_idx_t rd;
    rv32i_pkg::word_t    i_imm;
    rv32i_pkg::word_t    s_imm;
    rv32i_pkg::word_t    u_imm;
    rv32i_pkg::word_t    imm;
    rv32i_pkg::ctrl_t    ctrl;

    assign funct3 = id_instr[14:12];
    assign rd     = id_instr[11:7];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];

    assign i_imm = {{20{id_instr[31]}}, id_instr[31:20]};
    assign s_imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
    assign u_imm = {id_instr[31:12], 12'h000};

    always_comb begin
        ctrl = '0;
        imm  = i_imm;
        case (rv32i_pkg::opcode_e'(id_instr[6:0]))
            rv32i_pkg::op_reg: begin
                ctrl.alu_op    = rv32i_pkg::alu_op_e'(funct3);
                ctrl.alu_alt   = id_instr[30];
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                ctrl.alu_op    = rv32i_pkg::alu_op_e'(funct3);
                // only srai uses bit 30, for addi it is part of the immediate
                ctrl.alu_alt   = (funct3 == 3'b101) && id_instr[30];
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::op_lui: begin
                imm            = u_imm;
                ctrl.wb_sel    = rv32i_pkg::wb_u_imm;
                ctrl.reg_write = 1'b1;
            end
            rv32i_pkg::op_load: begin
                ctrl.b_imm     = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.size      = rv32i_pkg::mem_size_e'(funct3[1:0]);
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.wb_sel = rv32i_pkg::wb_lb;
                    3'b001:  ctrl.wb_sel = rv32i_pkg::wb_lh;
                    3'b100:  ctrl.wb_sel = rv32i_pkg::wb_lbu;
                    3'b101:  ctrl.wb_sel = rv32i_pkg::wb_lhu;
                    default: ctrl.wb_sel = rv32i_pkg::wb_lw;
                endcase
            end
            rv32i_pkg::op_store: begin
                imm            = s_imm;
                ctrl.b_imm     = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.size      = rv32i_pkg::mem_size_e'(funct3[1:0]);
            end
            default: ;
        endcase
        // x0 is never a forwarding source
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // ID/EX control, bubble takes the slot of the held instruction
    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            ex_ctrl <= '0;
        end else if (advance) begin
            ex_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rd  <= rd;
            ex_a   <= rs1_val;
            ex_b   <= rs2_val;
            ex_imm <= imm;
        end
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  rv32i_pkg::reg_idx_t waddr,
    input  rv32i_pkg::reg_idx_t raddr_a,
    input  rv32i_pkg::reg_idx_t raddr_b,
    input  rv32i_pkg::word_t    wdata,
    output rv32i_pkg::word_t    rdata_a,
    output rv32i_pkg::word_t    rdata_b
);

    rv32i_pkg::word_t regs [32];

    // same-cycle write shows up on the read port
    function automatic rv32i_pkg::word_t read_port(input rv32i_pkg::reg_idx_t raddr);
        if (we && waddr != '0 && waddr == raddr) begin
            return wdata;
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_read,
    input  logic                 instr_resp,
    input  logic                 data_read,
    input  logic                 data_write,
    input  logic                 data_resp,
    input  rv32i_pkg::reg_idx_t  id_rs1,
    input  rv32i_pkg::reg_idx_t  id_rs2,
    input  rv32i_pkg::reg_idx_t  ex_rd,
    input  rv32i_pkg::reg_idx_t  mem_rd,
    input  rv32i_pkg::reg_idx_t  wb_rd,
    input  logic                 ex_is_load,
    input  logic                 ex_we,
    input  logic                 mem_we,
    input  logic                 wb_we,
    output logic                 stall,
    output logic                 load_hold,
    output rv32i_pkg::fwd_sel_e  fwd_a_sel,
    output rv32i_pkg::fwd_sel_e  fwd_b_sel
);

    logic use_hazard;

    // youngest producer wins
    function automatic rv32i_pkg::fwd_sel_e pick_src(input rv32i_pkg::reg_idx_t rs);
        if (ex_we && ex_rd == rs) begin
            return rv32i_pkg::fwd_ex;
        end else if (mem_we && mem_rd == rs) begin
            return rv32i_pkg::fwd_mem;
        end else if (wb_we && wb_rd == rs) begin
            return rv32i_pkg::fwd_wb;
        end
        return rv32i_pkg::fwd_rf;
    endfunction

    // either memory still owes an answer
    assign stall = (instr_read && !instr_resp) || ((data_read || data_write) && !data_resp);

    assign use_hazard = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // only counts on an edge that actually moves the pipeline
    assign load_hold = use_hazard && !stall;

    always_comb begin
        fwd_a_sel = pick_src(id_rs1);
        fwd_b_sel = pick_src(id_rs2);
    end

    // the load has left execute after one bubble, so the hold cannot repeat
    a_one_bubble: assert property (
        @(posedge clk) disable iff (!rst_n) load_hold |=> !load_hold
    );

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  rv32i_pkg::ctrl_t    ex_ctrl,
    input  rv32i_pkg::reg_idx_t ex_rd,
    input  rv32i_pkg::word_t    ex_a,
    input  rv32i_pkg::word_t    ex_b,
    input  rv32i_pkg::word_t    ex_imm,
    output rv32i_pkg::word_t    ex_result,
    output rv32i_pkg::ctrl_t    mem_ctrl,
    output rv32i_pkg::reg_idx_t mem_rd,
    output rv32i_pkg::word_t    mem_result,
    output rv32i_pkg::word_t    mem_store_val,
    output rv32i_pkg::byte_en_t mem_mbe
);

    rv32i_pkg::word_t    op_b;
    rv32i_pkg::word_t    alu_out;
    rv32i_pkg::byte_en_t mbe;
    logic [4:0]          shamt;

    assign op_b  = ex_ctrl.b_imm ? ex_imm : ex_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_ctrl.alu_op)
            rv32i_pkg::alu_add: begin
                if (ex_ctrl.alu_alt) begin
                    alu_out = ex_a - op_b;
                end else begin
                    alu_out = ex_a + op_b;
                end
            end
            rv32i_pkg::alu_sll:  alu_out = ex_a << shamt;
            rv32i_pkg::alu_slt:  alu_out = {31'b0, $signed(ex_a) < $signed(op_b)};
            rv32i_pkg::alu_sltu: alu_out = {31'b0, ex_a < op_b};
            rv32i_pkg::alu_xor:  alu_out = ex_a ^ op_b;
            rv32i_pkg::alu_sr: begin
                // kept apart so the arithmetic shift stays signed
                if (ex_ctrl.alu_alt) begin
                    alu_out = $signed(ex_a) >>> shamt;
                end else begin
                    alu_out = ex_a >> shamt;
                end
            end
            rv32i_pkg::alu_or:   alu_out = ex_a | op_b;
            default:             alu_out = ex_a & op_b;
        endcase
    end

    // lui passes its immediate straight through
    assign ex_result = (ex_ctrl.wb_sel == rv32i_pkg::wb_u_imm) ? ex_imm : alu_out;

    // lanes from size and address offset
    always_comb begin
        mbe = '0;
        if (ex_ctrl.mem_read || ex_ctrl.mem_write) begin
            case (ex_ctrl.size)
                rv32i_pkg::size_byte: mbe = 4'b0001 << ex_result[1:0];
                rv32i_pkg::size_half: mbe = 4'b0011 << ex_result[1:0];
                default:              mbe = 4'b1111;
            endcase
        end
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ctrl <= '0;
        end else if (advance) begin
            mem_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_rd        <= ex_rd;
            mem_result    <= ex_result;
            mem_store_val <= ex_b;
            mem_mbe       <= mbe;
        end
    end

endmodule

`default_nettype wire

/* design/memory_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  rv32i_pkg::ctrl_t    mem_ctrl,
    input  rv32i_pkg::reg_idx_t mem_rd,
    input  rv32i_pkg::word_t    mem_result,
    input  rv32i_pkg::word_t    mem_store_val,
    input  rv32i_pkg::byte_en_t mem_mbe,
    input  rv32i_pkg::word_t    data_rdata,
    output logic                data_read,
    output logic                data_write,
    output rv32i_pkg::word_t    data_addr,
    output rv32i_pkg::word_t    data_wdata,
    output rv32i_pkg::byte_en_t data_mbe,
    output rv32i_pkg::word_t    mem_fwd,
    output logic                wb_we,
    output rv32i_pkg::reg_idx_t wb_rd,
    output rv32i_pkg::word_t    wb_value
);

    logic [1:0]  offset;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // request straight from EX/MEM, held there until resp
    assign data_read  = mem_ctrl.mem_read;
    assign data_write = mem_ctrl.mem_write;
    assign data_addr  = {mem_result[31:2], 2'b00};
    assign data_mbe   = mem_mbe;

    // every lane carries the value, mbe picks the ones written
    always_comb begin
        case (mem_ctrl.size)
            rv32i_pkg::size_byte: data_wdata = {4{mem_store_val[7:0]}};
            rv32i_pkg::size_half: data_wdata = {2{mem_store_val[15:0]}};
            default:              data_wdata = mem_store_val;
        endcase
    end

    assign offset = mem_result[1:0];
    assign lane_b = data_rdata[{offset, 3'b000} +: 8];
    assign lane_h = offset[1] ? data_rdata[31:16] : data_rdata[15:0];

    // loaded lane or alu value, also the memory-stage forward
    always_comb begin
        case (mem_ctrl.wb_sel)
            rv32i_pkg::wb_lw:  mem_fwd = data_rdata;
            rv32i_pkg::wb_lh:  mem_fwd = {{16{lane_h[15]}}, lane_h};
            rv32i_pkg::wb_lhu: mem_fwd = {16'h0000, lane_h};
            rv32i_pkg::wb_lb:  mem_fwd = {{24{lane_b[7]}}, lane_b};
            rv32i_pkg::wb_lbu: mem_fwd = {24'h00_0000, lane_b};
            default:           mem_fwd = mem_result;
        endcase
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else if (advance) begin
            wb_we <= mem_ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_rd    <= mem_rd;
            wb_value <= mem_fwd;
        end
    end

    // back-pressure must not move a pending request
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_read || data_write) && !advance |=> $stable(data_addr) && $stable(data_wdata)
    );

endmodule

`default_nettype wire

/* design/rv32i_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32i_core #(
    parameter rv32i_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic                instr_read,
    output rv32i_pkg::word_t    instr_addr,
    input  logic                instr_resp,
    input  rv32i_pkg::word_t    instr_rdata,
    output logic                data_read,
    output logic                data_write,
    output rv32i_pkg::byte_en_t data_mbe,
    output rv32i_pkg::word_t    data_addr,
    output rv32i_pkg::word_t    data_wdata,
    input  logic                data_resp,
    input  rv32i_pkg::word_t    data_rdata
);

    logic                stall;
    logic                load_hold;
    logic                front_adv;
    logic                back_adv;
    rv32i_pkg::fwd_sel_e fwd_a_sel;
    rv32i_pkg::fwd_sel_e fwd_b_sel;

    rv32i_pkg::word_t    id_instr;
    rv32i_pkg::reg_idx_t id_rs1;
    rv32i_pkg::reg_idx_t id_rs2;
    rv32i_pkg::word_t    rf_a;
    rv32i_pkg::word_t    rf_b;
    rv32i_pkg::word_t    rs1_val;
    rv32i_pkg::word_t    rs2_val;

    rv32i_pkg::ctrl_t    ex_ctrl;
    rv32i_pkg::reg_idx_t ex_rd;
    rv32i_pkg::word_t    ex_a;
    rv32i_pkg::word_t    ex_b;
    rv32i_pkg::word_t    ex_imm;
    rv32i_pkg::word_t    ex_result;

    rv32i_pkg::ctrl_t    mem_ctrl;
    rv32i_pkg::reg_idx_t mem_rd;
    rv32i_pkg::word_t    mem_result;
    rv32i_pkg::word_t    mem_store_val;
    rv32i_pkg::byte_en_t mem_mbe;
    rv32i_pkg::word_t    mem_fwd;

    logic                wb_we;
    rv32i_pkg::reg_idx_t wb_rd;
    rv32i_pkg::word_t    wb_value;

    function automatic rv32i_pkg::word_t fwd_mux(
        input rv32i_pkg::fwd_sel_e sel,
        input rv32i_pkg::word_t    rf_val
    );
        case (sel)
            rv32i_pkg::fwd_ex:  return ex_result;
            rv32i_pkg::fwd_mem: return mem_fwd;
            rv32i_pkg::fwd_wb:  return wb_value;
            default:            return rf_val;
        endcase
    endfunction

    assign instr_read = rst_n;

    // front end also waits out a load-use hold
    assign front_adv = !stall && !load_hold;
    assign back_adv  = !stall;

    always_comb begin
        rs1_val = fwd_mux(fwd_a_sel, rf_a);
        rs2_val = fwd_mux(fwd_b_sel, rf_b);
    end

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (front_adv),
        .instr_rdata (instr_rdata),
        .instr_addr  (instr_addr),
        .id_instr    (id_instr)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (front_adv),
        .bubble  (load_hold),
        .id_instr(id_instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rs1     (id_rs1),
        .rs2     (id_rs2),
        .ex_ctrl (ex_ctrl),
        .ex_rd   (ex_rd),
        .ex_a    (ex_a),
        .ex_b    (ex_b),
        .ex_imm  (ex_imm)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (wb_we),
        .waddr   (wb_rd),
        .raddr_a (id_rs1),
        .raddr_b (id_rs2),
        .wdata   (wb_value),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    hazard_unit u_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_read (instr_read),
        .instr_resp (instr_resp),
        .data_read  (data_read),
        .data_write (data_write),
        .data_resp  (data_resp),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex_rd      (ex_rd),
        .mem_rd     (mem_rd),
        .wb_rd      (wb_rd),
        .ex_is_load (ex_ctrl.mem_read),
        .ex_we      (ex_ctrl.reg_write),
        .mem_we     (mem_ctrl.reg_write),
        .wb_we      (wb_we),
        .stall      (stall),
        .load_hold  (load_hold),
        .fwd_a_sel  (fwd_a_sel),
        .fwd_b_sel  (fwd_b_sel)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance       (back_adv),
        .ex_ctrl       (ex_ctrl),
        .ex_rd         (ex_rd),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_imm        (ex_imm),
        .ex_result     (ex_result),
        .mem_ctrl      (mem_ctrl),
        .mem_rd        (mem_rd),
        .mem_result    (mem_result),
        .mem_store_val (mem_store_val),
        .mem_mbe       (mem_mbe)
    );

    memory_writeback u_mem_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance       (back_adv),
        .mem_ctrl      (mem_ctrl),
        .mem_rd        (mem_rd),
        .mem_result    (mem_result),
        .mem_store_val (mem_store_val),
        .mem_mbe       (mem_mbe),
        .data_rdata    (data_rdata),
        .data_read     (data_read),
        .data_write    (data_write),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_mbe      (data_mbe),
        .mem_fwd       (mem_fwd),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_value      (wb_value)
    );

endmodule

`default_nettype wire

/* sim/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    logic                clk;
    logic                rst_n;
    logic                instr_read;
    rv32i_pkg::word_t    instr_addr;
    logic                instr_resp;
    rv32i_pkg::word_t    instr_rdata;
    logic                data_read;
    logic                data_write;
    rv32i_pkg::byte_en_t data_mbe;
    rv32i_pkg::word_t    data_addr;
    rv32i_pkg::word_t    data_wdata;
    logic                data_resp;
    rv32i_pkg::word_t    data_rdata;

    // program and expected stores filled side by side
    rv32i_pkg::word_t    prog [$];
    rv32i_pkg::word_t    exp_addr [$];
    rv32i_pkg::byte_en_t exp_mbe [$];
    rv32i_pkg::word_t    exp_data [$];
    rv32i_pkg::word_t    dmem [64];

    int i_wait;
    int d_wait;
    int errors;
    int store_idx;

    rv32i_core #(
        .RESET_PC (32'h0000_0000)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_read  (instr_read),
        .instr_addr  (instr_addr),
        .instr_resp  (instr_resp),
        .instr_rdata (instr_rdata),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_mbe    (data_mbe),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_resp   (data_resp),
        .data_rdata  (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RV32I encodings
    function automatic rv32i_pkg::word_t alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                                 input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic rv32i_pkg::word_t alu_imm(input logic [2:0] f3, input int rd,
                                                 input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic rv32i_pkg::word_t load(input logic [2:0] f3, input int rd,
                                              input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0000011};
    endfunction

    function automatic rv32i_pkg::word_t store(input logic [2:0] f3, input int rs2,
                                               input int rs1, input logic [11:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_pkg::word_t lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    function automatic rv32i_pkg::word_t lane_mask(input rv32i_pkg::byte_en_t mbe);
        rv32i_pkg::word_t mask;
        for (int k = 0; k < 4; k++) begin
            mask[8*k +: 8] = {8{mbe[k]}};
        end
        return mask;
    endfunction

    task automatic emit(input rv32i_pkg::word_t instr);
        prog.push_back(instr);
    endtask

    task automatic expect_store(input rv32i_pkg::word_t addr, input rv32i_pkg::byte_en_t mbe,
                                input rv32i_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_mbe.push_back(mbe);
        exp_data.push_back(data);
    endtask

    // x1 = 12345678, x2 = fedcbdef, x3 = store base 0x80
    task automatic build_program();
        emit(lui(1, 20'h12345));
        emit(alu_imm(3'b000, 1, 1, 12'h678));
        emit(lui(2, 20'hfedcc));
        emit(alu_imm(3'b000, 2, 2, 12'hdef));
        emit(alu_imm(3'b000, 3, 0, 12'h080));
        emit(alu_reg(7'h00, 3'b000, 4, 1, 2));
        emit(store(3'b010, 4, 3, 12'h000));
        expect_store(32'h80, 4'hf, 32'h1111_1467);
        emit(alu_reg(7'h20, 3'b000, 5, 1, 2));
        emit(alu_reg(7'h00, 3'b111, 6, 1, 2));
        emit(store(3'b010, 5, 3, 12'h004));
        expect_store(32'h84, 4'hf, 32'h1357_9889);
        emit(store(3'b010, 6, 3, 12'h008));
        expect_store(32'h88, 4'hf, 32'h1214_1468);
        emit(alu_reg(7'h00, 3'b110, 7, 1, 2));
        emit(alu_reg(7'h00, 3'b100, 8, 1, 2));
        emit(alu_imm(3'b000, 9, 0, 12'h004));
        emit(store(3'b010, 7, 3, 12'h00c));
        expect_store(32'h8c, 4'hf, 32'hfefc_ffff);
        // shifts by x9 = 4
        emit(alu_reg(7'h00, 3'b001, 10, 1, 9));
        emit(alu_reg(7'h00, 3'b101, 11, 2, 9));
        emit(alu_reg(7'h20, 3'b101, 12, 2, 9));
        emit(store(3'b010, 8, 3, 12'h010));
        expect_store(32'h90, 4'hf, 32'hece8_eb97);
        emit(store(3'b010, 10, 3, 12'h014));
        expect_store(32'h94, 4'hf, 32'h2345_6780);
        emit(store(3'b010, 11, 3, 12'h018));
        expect_store(32'h98, 4'hf, 32'h0fed_cbde);
        emit(store(3'b010, 12, 3, 12'h01c));
        expect_store(32'h9c, 4'hf, 32'hffed_cbde);
        emit(alu_reg(7'h00, 3'b010, 13, 2, 1));
        emit(alu_reg(7'h00, 3'b011, 14, 2, 1));
        emit(store(3'b010, 13, 3, 12'h020));
        expect_store(32'ha0, 4'hf, 32'h0000_0001);
        emit(store(3'b010, 14, 3, 12'h024));
        expect_store(32'ha4, 4'hf, 32'h0000_0000);
        // slti -1, srai 8, addi -1000
        emit(alu_imm(3'b010, 15, 2, 12'hfff));
        emit(alu_imm(3'b101, 16, 2, 12'h408));
        emit(alu_imm(3'b000, 17, 1, 12'hc18));
        emit(store(3'b010, 15, 3, 12'h028));
        expect_store(32'ha8, 4'hf, 32'h0000_0001);
        emit(store(3'b010, 16, 3, 12'h02c));
        expect_store(32'hac, 4'hf, 32'hfffe_dcbd);
        emit(store(3'b010, 17, 3, 12'h030));
        expect_store(32'hb0, 4'hf, 32'h1234_5290);
        emit(alu_imm(3'b000, 0, 0, 12'h07b));
        emit(store(3'b010, 0, 3, 12'h034));
        expect_store(32'hb4, 4'hf, 32'h0000_0000);
        // loads from 0x40, which holds 9a900551, each used right away
        emit(alu_imm(3'b000, 20, 0, 12'h040));
        emit(load(3'b010, 21, 20, 12'h000));
        emit(store(3'b010, 21, 3, 12'h038));
        expect_store(32'hb8, 4'hf, 32'h9a90_0551);
        emit(load(3'b000, 22, 20, 12'h002));
        emit(store(3'b010, 22, 3, 12'h03c));
        expect_store(32'hbc, 4'hf, 32'hffff_ff90);
        emit(load(3'b100, 23, 20, 12'h003));
        emit(store(3'b010, 23, 3, 12'h040));
        expect_store(32'hc0, 4'hf, 32'h0000_009a);
        emit(load(3'b000, 24, 20, 12'h000));
        emit(store(3'b010, 24, 3, 12'h044));
        expect_store(32'hc4, 4'hf, 32'h0000_0051);
        emit(load(3'b100, 25, 20, 12'h001));
        emit(store(3'b010, 25, 3, 12'h048));
        expect_store(32'hc8, 4'hf, 32'h0000_0005);
        emit(load(3'b001, 26, 20, 12'h002));
        emit(store(3'b010, 26, 3, 12'h04c));
        expect_store(32'hcc, 4'hf, 32'hffff_9a90);
        emit(load(3'b101, 27, 20, 12'h002));
        emit(store(3'b010, 27, 3, 12'h050));
        expect_store(32'hd0, 4'hf, 32'h0000_9a90);
        emit(load(3'b001, 28, 20, 12'h000));
        emit(store(3'b010, 28, 3, 12'h054));
        expect_store(32'hd4, 4'hf, 32'h0000_0551);
        // byte and half stores at every offset
        emit(store(3'b000, 1, 3, 12'h058));
        expect_store(32'hd8, 4'b0001, 32'h0000_0078);
        emit(store(3'b000, 1, 3, 12'h059));
        expect_store(32'hd8, 4'b0010, 32'h0000_7800);
        emit(store(3'b000, 1, 3, 12'h05a));
        expect_store(32'hd8, 4'b0100, 32'h0078_0000);
        emit(store(3'b000, 1, 3, 12'h05b));
        expect_store(32'hd8, 4'b1000, 32'h7800_0000);
        emit(store(3'b001, 2, 3, 12'h05c));
        expect_store(32'hdc, 4'b0011, 32'h0000_bdef);
        emit(store(3'b001, 2, 3, 12'h05e));
        expect_store(32'hdc, 4'b1100, 32'hbdef_0000);
        emit(load(3'b010, 29, 3, 12'h058));
        emit(store(3'b010, 29, 3, 12'h060));
        expect_store(32'he0, 4'hf, 32'h7878_7878);
    endtask

    // new delays after every edge that moved the pipeline, else count down
    task automatic serve_memories(input bit fresh);
        int idx;
        if (fresh) begin
            i_wait = $urandom_range(3, 0);
            d_wait = $urandom_range(3, 0);
        end else begin
            if (i_wait > 0) begin
                i_wait--;
            end
            if (d_wait > 0) begin
                d_wait--;
            end
        end
        idx = int'(instr_addr >> 2);
        instr_rdata = (idx < prog.size()) ? prog[idx] : rv32i_pkg::NOP_INSTR;
        instr_resp  = rst_n && i_wait == 0;
        // read data only comes back for a read request
        data_rdata  = data_read ? dmem[data_addr[7:2]] : '0;
        data_resp   = (data_read || data_write) && d_wait == 0;
    endtask

    task automatic check_store();
        rv32i_pkg::word_t mask;
        if (store_idx >= exp_addr.size()) begin
            $display("unexpected extra store to address %h", data_addr);
            errors++;
        end else begin
            mask = lane_mask(exp_mbe[store_idx]);
            if (data_addr !== exp_addr[store_idx]) begin
                $display("Error: data_addr = %h, expected %h", data_addr, exp_addr[store_idx]);
                errors++;
            end
            if (data_mbe !== exp_mbe[store_idx]) begin
                $display("Error: data_mbe = %h, expected %h", data_mbe, exp_mbe[store_idx]);
                errors++;
            end
            if ((data_wdata & mask) !== (exp_data[store_idx] & mask)) begin
                $display("Error: data_wdata = %h, expected %h", data_wdata & mask,
                         exp_data[store_idx] & mask);
                errors++;
            end
            store_idx++;
        end
        for (int k = 0; k < 4; k++) begin
            if (data_mbe[k]) begin
                dmem[data_addr[7:2]][8*k +: 8] = data_wdata[8*k +: 8];
            end
        end
    endtask

    initial begin
        int  cycles;
        int  limit;
        int  drain;
        bit  moved;
        bit  finished;
        void'($urandom(32'hf757_f644));
        rst_n       = 1'b0;
        instr_resp  = 1'b0;
        instr_rdata = rv32i_pkg::NOP_INSTR;
        data_resp   = 1'b0;
        data_rdata  = '0;
        errors      = 0;
        store_idx   = 0;
        cycles      = 0;
        drain       = 0;
        finished    = 1'b0;
        build_program();
        // pattern follows the byte address of each word
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'h9a90_0511 ^ (32'(i) << 2);
        end
        limit = (prog.size() * 5 + 50) * 4;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        moved = 1'b1;
        while (!finished) begin
            serve_memories(moved);
            // requests and answers are settled by mid-cycle
            @(negedge clk);
            if (instr_read !== 1'b1) begin
                $display("Error: instr_read = %h, expected 1", instr_read);
                errors++;
            end
            moved = instr_resp && (!(data_read || data_write) || data_resp);
            if (moved && data_write) begin
                check_store();
            end
            cycles++;
            if (store_idx == exp_addr.size()) begin
                drain++;
            end
            if (drain == 20) begin
                finished = 1'b1;
            end else if (cycles >= limit) begin
                $display("timeout after %0d cycles, only %0d of %0d stores seen",
                         cycles, store_idx, exp_addr.size());
                errors++;
                finished = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end

        $display("%0d errors, %0d of %0d stores checked", errors, store_idx, exp_addr.size());
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
design/rv32i_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_writeback.sv
design/rv32i_core.sv
sim/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run tb_core with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f list.f > build.log 2>&1 \
    || { cat build.log; exit 1; }

./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
